// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

	////////////////////////////////////////
	// basic widths and words
	////////////////////////////////////////

	// data and pc width
	localparam int xlen_c = 32;

	typedef logic [4:0]        reg_idx_t;
	typedef logic [xlen_c-1:0] word_t;

	// jal and jalr always link here
	localparam reg_idx_t link_reg_c = 5'd31;

	// regimm selector in the rt field
	localparam reg_idx_t rt_bltz_c = 5'd0;
	localparam reg_idx_t rt_bgez_c = 5'd1;

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	// major opcodes, kept subset only
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_regimm  = 6'h01,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_blez    = 6'h06,
		op_bgtz    = 6'h07,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_aui     = 6'h0f
	} opcode_e;

	// special function field
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_sllv = 6'h04,
		fn_srlv = 6'h06,
		fn_srav = 6'h07,
		fn_jr   = 6'h08,
		fn_jalr = 6'h09,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	////////////////////////////////////////
	// decode results
	////////////////////////////////////////

	// shifts take the amount on src1, the value on src2
	typedef enum logic [3:0] {
		alu_nop, alu_addu, alu_subu, alu_and, alu_or, alu_xor,
		alu_nor, alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	// all zero compares look at rs
	typedef enum logic [3:0] {
		cond_never, cond_always, cond_eq, cond_ne,
		cond_lez, cond_gtz, cond_ltz, cond_gez
	} branch_cond_e;

	typedef enum logic [1:0] {
		tgt_pc_rel, tgt_region, tgt_reg
	} target_kind_e;

	typedef enum logic [1:0] {
		src1_reg, src1_shamt, src1_link
	} src1_kind_e;

	typedef enum logic [1:0] {
		src2_reg, src2_simm, src2_zimm, src2_uimm
	} src2_kind_e;

	// three views of one instruction word
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} insn_u;

	////////////////////////////////////////
	// port records
	////////////////////////////////////////

	typedef struct packed {
		logic  valid;
		insn_u insn;
		word_t pc;
	} fetch_t;

	// imm carries the low 26 bits, shamt and imm16 live inside it
	typedef struct packed {
		logic         valid;
		reg_idx_t     rs;
		reg_idx_t     rt;
		logic         use_rs;
		logic         use_rt;
		reg_idx_t     dst;
		alu_op_e      alu_op;
		src1_kind_e   src1_kind;
		src2_kind_e   src2_kind;
		branch_cond_e cond;
		target_kind_e target;
		word_t        pc;
		logic [25:0]  imm;
	} decode_ctrl_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t idx;
		word_t    data;
	} wb_t;

	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		word_t    src1;
		word_t    src2;
		reg_idx_t dst;
		word_t    pc;
	} issue_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

// File: rtl/insn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module insn_classifier (
	input  wire                       CLK,
	input  wire                       RST,
	input  decode_pkg::fetch_t        fetch,
	input  wire                       stall,
	output decode_pkg::decode_ctrl_t  ctrl
);

	////////////////////////////////////////
	// decode register
	////////////////////////////////////////

	logic                held_valid_q;
	decode_pkg::insn_u   held_insn_q;
	decode_pkg::word_t   held_pc_q;
	logic                accept;

	// upstream word taken only when not stalled
	assign accept = fetch.valid && !stall;

	// without stall the held word leaves this cycle, so valid follows fetch
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			held_valid_q <= 1'b0;
		end else if (!stall) begin
			held_valid_q <= fetch.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			held_insn_q <= fetch.insn;
			held_pc_q   <= fetch.pc;
		end
	end

	////////////////////////////////////////
	// instruction views
	////////////////////////////////////////

	decode_pkg::r_fmt_t r_view;
	decode_pkg::i_fmt_t i_view;
	decode_pkg::j_fmt_t j_view;

	assign r_view = held_insn_q.r_fmt;
	assign i_view = held_insn_q.i_fmt;
	assign j_view = held_insn_q.j_fmt;

	////////////////////////////////////////
	// classify
	////////////////////////////////////////

	always_comb begin
		// defaults give no op, no branch, no destination
		ctrl           = '0;
		ctrl.valid     = held_valid_q;
		ctrl.pc        = held_pc_q;
		ctrl.imm       = j_view.index26;
		ctrl.alu_op    = decode_pkg::alu_nop;
		ctrl.cond      = decode_pkg::cond_never;
		ctrl.target    = decode_pkg::tgt_pc_rel;
		ctrl.src1_kind = decode_pkg::src1_reg;
		ctrl.src2_kind = decode_pkg::src2_reg;

		// rs and rt sit in the same bits for every format
		ctrl.rs = i_view.rs;
		ctrl.rt = i_view.rt;

		case (i_view.opcode)
			decode_pkg::op_special: begin
				// three-register form unless overridden below
				ctrl.dst    = r_view.rd;
				ctrl.use_rs = 1'b1;
				ctrl.use_rt = 1'b1;
				case (r_view.funct)
					decode_pkg::fn_addu: ctrl.alu_op = decode_pkg::alu_addu;
					decode_pkg::fn_subu: ctrl.alu_op = decode_pkg::alu_subu;
					decode_pkg::fn_and:  ctrl.alu_op = decode_pkg::alu_and;
					decode_pkg::fn_or:   ctrl.alu_op = decode_pkg::alu_or;
					decode_pkg::fn_xor:  ctrl.alu_op = decode_pkg::alu_xor;
					decode_pkg::fn_nor:  ctrl.alu_op = decode_pkg::alu_nor;
					decode_pkg::fn_slt:  ctrl.alu_op = decode_pkg::alu_slt;
					decode_pkg::fn_sltu: ctrl.alu_op = decode_pkg::alu_sltu;
					// variable shifts, amount from rs
					decode_pkg::fn_sllv: ctrl.alu_op = decode_pkg::alu_sll;
					decode_pkg::fn_srlv: ctrl.alu_op = decode_pkg::alu_srl;
					decode_pkg::fn_srav: ctrl.alu_op = decode_pkg::alu_sra;
					// fixed shifts, amount from shamt
					decode_pkg::fn_sll, decode_pkg::fn_srl, decode_pkg::fn_sra: begin
						ctrl.use_rs    = 1'b0;
						ctrl.src1_kind = decode_pkg::src1_shamt;
						if (r_view.funct == decode_pkg::fn_sll) begin
							ctrl.alu_op = decode_pkg::alu_sll;
						end else if (r_view.funct == decode_pkg::fn_srl) begin
							ctrl.alu_op = decode_pkg::alu_srl;
						end else begin
							ctrl.alu_op = decode_pkg::alu_sra;
						end
					end
					decode_pkg::fn_jr: begin
						ctrl.dst    = '0;
						ctrl.use_rt = 1'b0;
						ctrl.cond   = decode_pkg::cond_always;
						ctrl.target = decode_pkg::tgt_reg;
					end
					// link goes through the alu as pc+8 plus zero
					decode_pkg::fn_jalr: begin
						ctrl.dst       = decode_pkg::link_reg_c;
						ctrl.use_rt    = 1'b0;
						ctrl.alu_op    = decode_pkg::alu_addu;
						ctrl.src1_kind = decode_pkg::src1_link;
						ctrl.cond      = decode_pkg::cond_always;
						ctrl.target    = decode_pkg::tgt_reg;
					end
					default: begin
						ctrl.dst    = '0;
						ctrl.use_rs = 1'b0;
						ctrl.use_rt = 1'b0;
					end
				endcase
			end
			decode_pkg::op_regimm: begin
				if (i_view.rt == decode_pkg::rt_bltz_c) begin
					ctrl.use_rs = 1'b1;
					ctrl.cond   = decode_pkg::cond_ltz;
				end else if (i_view.rt == decode_pkg::rt_bgez_c) begin
					ctrl.use_rs = 1'b1;
					ctrl.cond   = decode_pkg::cond_gez;
				end
			end
			decode_pkg::op_beq, decode_pkg::op_bne: begin
				ctrl.use_rs = 1'b1;
				ctrl.use_rt = 1'b1;
				if (i_view.opcode == decode_pkg::op_beq) begin
					ctrl.cond = decode_pkg::cond_eq;
				end else begin
					ctrl.cond = decode_pkg::cond_ne;
				end
			end
			decode_pkg::op_blez: begin
				ctrl.use_rs = 1'b1;
				ctrl.cond   = decode_pkg::cond_lez;
			end
			decode_pkg::op_bgtz: begin
				ctrl.use_rs = 1'b1;
				ctrl.cond   = decode_pkg::cond_gtz;
			end
			decode_pkg::op_j: begin
				ctrl.cond   = decode_pkg::cond_always;
				ctrl.target = decode_pkg::tgt_region;
			end
			decode_pkg::op_jal: begin
				ctrl.dst       = decode_pkg::link_reg_c;
				ctrl.alu_op    = decode_pkg::alu_addu;
				ctrl.src1_kind = decode_pkg::src1_link;
				ctrl.cond      = decode_pkg::cond_always;
				ctrl.target    = decode_pkg::tgt_region;
			end
			// immediate forms write rt
			decode_pkg::op_addiu, decode_pkg::op_slti, decode_pkg::op_sltiu: begin
				ctrl.dst       = i_view.rt;
				ctrl.use_rs    = 1'b1;
				ctrl.src2_kind = decode_pkg::src2_simm;
				if (i_view.opcode == decode_pkg::op_addiu) begin
					ctrl.alu_op = decode_pkg::alu_addu;
				end else if (i_view.opcode == decode_pkg::op_slti) begin
					ctrl.alu_op = decode_pkg::alu_slt;
				end else begin
					ctrl.alu_op = decode_pkg::alu_sltu;
				end
			end
			decode_pkg::op_andi, decode_pkg::op_ori, decode_pkg::op_xori: begin
				ctrl.dst       = i_view.rt;
				ctrl.use_rs    = 1'b1;
				ctrl.src2_kind = decode_pkg::src2_zimm;
				if (i_view.opcode == decode_pkg::op_andi) begin
					ctrl.alu_op = decode_pkg::alu_and;
				end else if (i_view.opcode == decode_pkg::op_ori) begin
					ctrl.alu_op = decode_pkg::alu_or;
				end else begin
					ctrl.alu_op = decode_pkg::alu_xor;
				end
			end
			// rs plus imm placed in the upper half
			decode_pkg::op_aui: begin
				ctrl.dst       = i_view.rt;
				ctrl.use_rs    = 1'b1;
				ctrl.alu_op    = decode_pkg::alu_addu;
				ctrl.src2_kind = decode_pkg::src2_uimm;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/reg_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard (
	input  wire                       CLK,
	input  wire                       RST,
	input  decode_pkg::decode_ctrl_t  ctrl,
	input  decode_pkg::wb_t           wb,
	input  wire                       lock_req_valid,
	input  decode_pkg::reg_idx_t      lock_req_reg,
	output decode_pkg::word_t         rs_value,
	output decode_pkg::word_t         rt_value,
	output logic                      rs_locked,
	output logic                      rt_locked
);

	// one read result, value plus lock
	typedef struct packed {
		logic              locked;
		decode_pkg::word_t value;
	} read_t;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// r0 has no storage
	decode_pkg::word_t regs_q [31:1];
	logic [31:0]       lock_q;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			for (int k = 1; k < 32; k++) begin
				regs_q[k] <= '0;
			end
		end else if (wb.valid && wb.idx != '0) begin
			regs_q[wb.idx] <= wb.data;
		end
	end

	// write-back clears, issue sets
	// a lock request on the same edge lands last
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			lock_q <= '0;
		end else begin
			if (wb.valid) begin
				lock_q[wb.idx] <= 1'b0;
			end
			if (lock_req_valid) begin
				lock_q[lock_req_reg] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	function automatic read_t read_reg(input decode_pkg::reg_idx_t idx);
		read_t r;
		if (idx == '0) begin
			r = '0;
		end else if (wb.valid && wb.idx == idx) begin
			// same-cycle write-back bypass
			r.locked = 1'b0;
			r.value  = wb.data;
		end else begin
			r.locked = lock_q[idx];
			r.value  = regs_q[idx];
		end
		return r;
	endfunction

	read_t rs_rd;
	read_t rt_rd;

	always_comb begin
		rs_rd = read_reg(ctrl.rs);
		rt_rd = read_reg(ctrl.rt);
	end

	assign rs_value  = rs_rd.value;
	assign rs_locked = rs_rd.locked;
	assign rt_value  = rt_rd.value;
	assign rt_locked = rt_rd.locked;

endmodule

`default_nettype wire

// File: rtl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire                       CLK,
	input  wire                       RST,
	input  decode_pkg::decode_ctrl_t  ctrl,
	input  decode_pkg::word_t         rs_value,
	input  decode_pkg::word_t         rt_value,
	input  wire                       rs_locked,
	input  wire                       rt_locked,
	output logic                      stall,
	output logic                      lock_req_valid,
	output decode_pkg::reg_idx_t      lock_req_reg,
	output decode_pkg::issue_t        issue,
	output decode_pkg::redirect_t     redirect
);

	////////////////////////////////////////
	// interlock
	////////////////////////////////////////

	logic fire;

	// wait while any used source is still pending
	assign stall = ctrl.valid && ((ctrl.use_rs && rs_locked) || (ctrl.use_rt && rt_locked));
	assign fire  = ctrl.valid && !stall;

	// r0 never gets locked
	assign lock_req_valid = fire && ctrl.dst != '0;
	assign lock_req_reg   = ctrl.dst;

	////////////////////////////////////////
	// operands
	////////////////////////////////////////

	decode_pkg::word_t src1_val;
	decode_pkg::word_t src2_val;
	decode_pkg::word_t imm_sext;

	assign imm_sext = {{16{ctrl.imm[15]}}, ctrl.imm[15:0]};

	// an unused rt reads as zero, the link ops rely on it
	always_comb begin
		case (ctrl.src1_kind)
			decode_pkg::src1_shamt: src1_val = {27'b0, ctrl.imm[10:6]};
			decode_pkg::src1_link:  src1_val = ctrl.pc + 32'd8;
			default:                src1_val = rs_value;
		endcase
		case (ctrl.src2_kind)
			decode_pkg::src2_simm: src2_val = imm_sext;
			decode_pkg::src2_zimm: src2_val = {16'b0, ctrl.imm[15:0]};
			decode_pkg::src2_uimm: src2_val = {ctrl.imm[15:0], 16'b0};
			default:               src2_val = ctrl.use_rt ? rt_value : '0;
		endcase
	end

	////////////////////////////////////////
	// branch condition and target
	////////////////////////////////////////

	logic              rs_eq_rt;
	logic              rs_is_zero;
	logic              rs_lt_zero;
	logic              taken;
	decode_pkg::word_t pc_plus4;
	decode_pkg::word_t target;

	assign rs_eq_rt   = rs_value == rt_value;
	assign rs_is_zero = rs_value == '0;
	assign rs_lt_zero = $signed(rs_value) < 0;
	assign pc_plus4   = ctrl.pc + 32'd4;

	always_comb begin
		case (ctrl.cond)
			decode_pkg::cond_always: taken = 1'b1;
			decode_pkg::cond_eq:     taken = rs_eq_rt;
			decode_pkg::cond_ne:     taken = !rs_eq_rt;
			decode_pkg::cond_lez:    taken = rs_lt_zero || rs_is_zero;
			decode_pkg::cond_gtz:    taken = !(rs_lt_zero || rs_is_zero);
			decode_pkg::cond_ltz:    taken = rs_lt_zero;
			decode_pkg::cond_gez:    taken = !rs_lt_zero;
			default:                 taken = 1'b0;
		endcase
		case (ctrl.target)
			// 256MB region of the slot address
			decode_pkg::tgt_region: target = {pc_plus4[31:28], ctrl.imm, 2'b00};
			decode_pkg::tgt_reg:    target = rs_value;
			default:                target = pc_plus4 + {imm_sext[29:0], 2'b00};
		endcase
	end

	////////////////////////////////////////
	// output registers
	////////////////////////////////////////

	// one-cycle pulses, payload only loads on fire
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			issue.valid    <= 1'b0;
			redirect.valid <= 1'b0;
		end else begin
			issue.valid    <= fire && ctrl.alu_op != decode_pkg::alu_nop;
			redirect.valid <= fire && taken;
			if (fire) begin
				issue.alu_op    <= ctrl.alu_op;
				issue.src1      <= src1_val;
				issue.src2      <= src2_val;
				issue.dst       <= ctrl.dst;
				issue.pc        <= ctrl.pc;
				redirect.target <= target;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
	input  wire                    CLK,
	input  wire                    RST,
	input  decode_pkg::fetch_t     fetch,
	output logic                   stall,
	input  decode_pkg::wb_t        wb,
	output decode_pkg::issue_t     issue,
	output decode_pkg::redirect_t  redirect
);

	// classifier to scoreboard and issue
	decode_pkg::decode_ctrl_t ctrl;

	// scoreboard reads back to issue
	decode_pkg::word_t rs_value;
	decode_pkg::word_t rt_value;
	logic              rs_locked;
	logic              rt_locked;

	// destination lock from issue
	logic                 lock_req_valid;
	decode_pkg::reg_idx_t lock_req_reg;

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	insn_classifier u_classifier (
		.CLK   (CLK),
		.RST   (RST),
		.fetch (fetch),
		.stall (stall),
		.ctrl  (ctrl)
	);

	reg_scoreboard u_scoreboard (
		.CLK            (CLK),
		.RST            (RST),
		.ctrl           (ctrl),
		.wb             (wb),
		.lock_req_valid (lock_req_valid),
		.lock_req_reg   (lock_req_reg),
		.rs_value       (rs_value),
		.rt_value       (rt_value),
		.rs_locked      (rs_locked),
		.rt_locked      (rt_locked)
	);

	issue_stage u_issue (
		.CLK            (CLK),
		.RST            (RST),
		.ctrl           (ctrl),
		.rs_value       (rs_value),
		.rt_value       (rt_value),
		.rs_locked      (rs_locked),
		.rt_locked      (rt_locked),
		.stall          (stall),
		.lock_req_valid (lock_req_valid),
		.lock_req_reg   (lock_req_reg),
		.issue          (issue),
		.redirect       (redirect)
	);

endmodule

`default_nettype wire

// File: dv/decode_properties.sv
`timescale 1ns/1ps
`default_nettype none

module decode_properties (
	input wire                    CLK,
	input wire                    RST,
	input wire                    stall,
	input decode_pkg::wb_t        wb,
	input decode_pkg::issue_t     issue,
	input decode_pkg::redirect_t  redirect,
	input wire [63:0]             held
);

	// a stalled instruction cannot issue at the next edge
	assert property (@(posedge CLK) disable iff (RST) stall |=> !issue.valid)
		else $error("issue raised after a stalled cycle");

	// r0 is never a write-back target
	assert property (@(posedge CLK) disable iff (RST) wb.valid |-> wb.idx != '0)
		else $error("write-back to register zero");

	// quiet outputs right after reset
	assert property (@(posedge CLK) $past(RST) && !RST |-> !stall && !issue.valid
		&& !redirect.valid)
		else $error("outputs active after reset");

	// held word and pc stay put under stall
	assert property (@(posedge CLK) disable iff (RST) stall |=> $stable(held))
		else $error("decode register changed under stall");

endmodule

bind decode_top decode_properties u_props (
	.CLK      (CLK),
	.RST      (RST),
	.stall    (stall),
	.wb       (wb),
	.issue    (issue),
	.redirect (redirect),
	.held     ({u_classifier.held_insn_q, u_classifier.held_pc_q})
);

`default_nettype wire

// File: dv/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode;

	logic                    CLK;
	logic                    RST;
	decode_pkg::fetch_t      fetch;
	decode_pkg::wb_t         wb;
	logic                    stall;
	decode_pkg::issue_t      issue;
	decode_pkg::redirect_t   redirect;

	decode_top u_dut (
		.CLK      (CLK),
		.RST      (RST),
		.fetch    (fetch),
		.stall    (stall),
		.wb       (wb),
		.issue    (issue),
		.redirect (redirect)
	);

	// 8 ns clock
	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	////////////////////////////////////////
	// state, table, shadow registers
	////////////////////////////////////////

	decode_pkg::word_t     shadow [0:31];
	logic [31:0]           lfsr = 32'h1c6a2e4a;
	int                    err_count;
	int                    pass_count;
	int                    fail_count;
	int                    cycles;
	int                    cycle_limit;
	logic                  row_bad;
	logic                  pending_valid;
	decode_pkg::reg_idx_t  pending_reg;

	// one row holds instruction, pc and write-back delay
	// a delay of 0 marks an independent row
	string                 row_name [$];
	decode_pkg::word_t     row_insn [$];
	decode_pkg::word_t     row_pc [$];
	int                    row_delay [$];
	decode_pkg::issue_t    exp_issue [0:63];
	decode_pkg::redirect_t exp_redirect [0:63];

	// run guard
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("run stopped, cycle limit of %0d reached without finishing", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output decode_pkg::word_t w);
		for (int k = 0; k < 32; k++) begin
			lfsr = lfsr_next(lfsr);
			w    = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic decode_pkg::word_t enc_r(input int rs, input int rt, input int rd,
		input int sh, input logic [5:0] fn);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic decode_pkg::word_t enc_i(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic decode_pkg::issue_t make_issue(input decode_pkg::alu_op_e op,
		input decode_pkg::word_t s1, input decode_pkg::word_t s2, input int d,
		input decode_pkg::word_t pc);
		decode_pkg::issue_t r;
		r.valid  = 1'b1;
		r.alu_op = op;
		r.src1   = s1;
		r.src2   = s2;
		r.dst    = 5'(d);
		r.pc     = pc;
		return r;
	endfunction

	// reference model of the decode rules on shadow values
	task automatic predict(input decode_pkg::word_t insn, input decode_pkg::word_t pc,
		output decode_pkg::issue_t ei, output decode_pkg::redirect_t er);
		logic [5:0]        op;
		logic [5:0]        fn;
		int                rd;
		int                rt;
		decode_pkg::word_t a;
		decode_pkg::word_t b;
		decode_pkg::word_t se;
		decode_pkg::word_t ze;
		decode_pkg::word_t pc4;
		op  = insn[31:26];
		fn  = insn[5:0];
		rd  = insn[15:11];
		rt  = insn[20:16];
		a   = shadow[insn[25:21]];
		b   = shadow[insn[20:16]];
		se  = {{16{insn[15]}}, insn[15:0]};
		ze  = {16'b0, insn[15:0]};
		pc4 = pc + 32'd4;
		ei  = '0;
		er  = '0;
		// pc-relative target, valid set per branch below
		er.target = pc4 + (se << 2);
		case (op)
			6'h00: begin
				case (fn)
					6'h21: ei = make_issue(decode_pkg::alu_addu, a, b, rd, pc);
					6'h23: ei = make_issue(decode_pkg::alu_subu, a, b, rd, pc);
					6'h24: ei = make_issue(decode_pkg::alu_and, a, b, rd, pc);
					6'h25: ei = make_issue(decode_pkg::alu_or, a, b, rd, pc);
					6'h26: ei = make_issue(decode_pkg::alu_xor, a, b, rd, pc);
					6'h27: ei = make_issue(decode_pkg::alu_nor, a, b, rd, pc);
					6'h2a: ei = make_issue(decode_pkg::alu_slt, a, b, rd, pc);
					6'h2b: ei = make_issue(decode_pkg::alu_sltu, a, b, rd, pc);
					6'h00: ei = make_issue(decode_pkg::alu_sll, 32'(insn[10:6]), b, rd, pc);
					6'h02: ei = make_issue(decode_pkg::alu_srl, 32'(insn[10:6]), b, rd, pc);
					6'h03: ei = make_issue(decode_pkg::alu_sra, 32'(insn[10:6]), b, rd, pc);
					6'h04: ei = make_issue(decode_pkg::alu_sll, a, b, rd, pc);
					6'h06: ei = make_issue(decode_pkg::alu_srl, a, b, rd, pc);
					6'h07: ei = make_issue(decode_pkg::alu_sra, a, b, rd, pc);
					6'h08: er = {1'b1, a};
					6'h09: begin
						ei = make_issue(decode_pkg::alu_addu, pc + 32'd8, '0, 31, pc);
						er = {1'b1, a};
					end
					default: ;
				endcase
			end
			6'h01: er.valid = (rt == 0) ? a[31] : ((rt == 1) ? !a[31] : 1'b0);
			6'h04: er.valid = a == b;
			6'h05: er.valid = a != b;
			6'h06: er.valid = a[31] || a == 0;
			6'h07: er.valid = !a[31] && a != 0;
			6'h02: er = {1'b1, pc4[31:28], insn[25:0], 2'b00};
			6'h03: begin
				ei = make_issue(decode_pkg::alu_addu, pc + 32'd8, '0, 31, pc);
				er = {1'b1, pc4[31:28], insn[25:0], 2'b00};
			end
			6'h09: ei = make_issue(decode_pkg::alu_addu, a, se, rt, pc);
			6'h0a: ei = make_issue(decode_pkg::alu_slt, a, se, rt, pc);
			6'h0b: ei = make_issue(decode_pkg::alu_sltu, a, se, rt, pc);
			6'h0c: ei = make_issue(decode_pkg::alu_and, a, ze, rt, pc);
			6'h0d: ei = make_issue(decode_pkg::alu_or, a, ze, rt, pc);
			6'h0e: ei = make_issue(decode_pkg::alu_xor, a, ze, rt, pc);
			6'h0f: ei = make_issue(decode_pkg::alu_addu, a, {insn[15:0], 16'b0}, rt, pc);
			default: ;
		endcase
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic compare_issue(input string name, input decode_pkg::issue_t got,
		input decode_pkg::issue_t exp);
		if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
			$display("Mismatch at %0t: %s issue got %h expected %h", $time, name, got, exp);
			err_count++;
			row_bad = 1'b1;
		end
	endtask

	task automatic compare_redirect(input string name, input decode_pkg::redirect_t got,
		input decode_pkg::redirect_t exp);
		if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
			$display("Mismatch at %0t: %s redirect got %h expected %h", $time, name, got, exp);
			err_count++;
			row_bad = 1'b1;
		end
	endtask

	task automatic compare_stall(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s stall got %b expected %b", $time, name, got, exp);
			err_count++;
			row_bad = 1'b1;
		end
	endtask

	// one write-back cycle, driven on the falling edge
	task automatic write_reg(input int idx, input decode_pkg::word_t val);
		wb = {1'b1, 5'(idx), val};
		shadow[idx] = val;
		@(negedge CLK);
		wb.valid = 1'b0;
	endtask

	task automatic add_row(input string name, input decode_pkg::word_t insn,
		input decode_pkg::word_t pc, input int delay);
		row_name.push_back(name);
		row_insn.push_back(insn);
		row_pc.push_back(pc);
		row_delay.push_back(delay);
	endtask

	task automatic finish_row(input string name);
		if (row_bad) begin
			fail_count++;
			$display("test %s failed", name);
		end else begin
			pass_count++;
			$display("test %s ok", name);
		end
	endtask

	////////////////////////////////////////
	// one table row
	////////////////////////////////////////

	task automatic apply_row(input int i);
		decode_pkg::word_t v;
		row_bad = 1'b0;
		if (row_delay[i] == 0 && pending_valid) begin
			// release the last destination lock
			rand_word(v);
			write_reg(pending_reg, v);
			pending_valid = 1'b0;
		end
		if (row_delay[i] > 0 && !pending_valid) begin
			$display("dependent row %s has no locked register to wait on", row_name[i]);
			err_count++;
			row_bad = 1'b1;
		end
		fetch = {1'b1, row_insn[i], row_pc[i]};
		@(negedge CLK);
		fetch.valid = 1'b0;
		if (row_delay[i] > 0) begin
			for (int k = 1; k < row_delay[i]; k++) begin
				compare_stall(row_name[i], stall, 1'b1);
				@(negedge CLK);
			end
			rand_word(v);
			wb = {1'b1, pending_reg, v};
			shadow[pending_reg] = v;
			pending_valid = 1'b0;
			#1;
		end
		compare_stall(row_name[i], stall, 1'b0);
		predict(row_insn[i], row_pc[i], exp_issue[i], exp_redirect[i]);
		@(negedge CLK);
		wb.valid = 1'b0;
		compare_issue(row_name[i], issue, exp_issue[i]);
		compare_redirect(row_name[i], redirect, exp_redirect[i]);
		if (exp_issue[i].valid && exp_issue[i].dst != 0) begin
			pending_valid = 1'b1;
			pending_reg   = exp_issue[i].dst;
		end
		finish_row(row_name[i]);
	endtask

	// two independent ops in consecutive cycles, rd zero so nothing locks
	task automatic back_to_back();
		decode_pkg::issue_t    ea;
		decode_pkg::issue_t    eb;
		decode_pkg::redirect_t ra;
		decode_pkg::redirect_t rb;
		row_bad = 1'b0;
		predict(enc_r(5, 6, 0, 0, 6'h21), 32'h200, ea, ra);
		predict(enc_r(9, 2, 0, 0, 6'h25), 32'h204, eb, rb);
		fetch = {1'b1, enc_r(5, 6, 0, 0, 6'h21), 32'h200};
		@(negedge CLK);
		fetch = {1'b1, enc_r(9, 2, 0, 0, 6'h25), 32'h204};
		@(negedge CLK);
		fetch.valid = 1'b0;
		compare_issue("b2b_first", issue, ea);
		compare_redirect("b2b_first", redirect, ra);
		@(negedge CLK);
		compare_issue("b2b_second", issue, eb);
		compare_redirect("b2b_second", redirect, rb);
		finish_row("b2b");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		decode_pkg::word_t v;
		int                max_delay;
		fetch         = '0;
		wb            = '0;
		RST           = 1'b1;
		err_count     = 0;
		pass_count    = 0;
		fail_count    = 0;
		cycles        = 0;
		cycle_limit   = 0;
		pending_valid = 1'b0;
		pending_reg   = '0;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = '0;
		end

		// alu register and shift ops
		add_row("addu", enc_r(5, 6, 11, 0, 6'h21), 32'h100, 0);
		add_row("subu", enc_r(3, 2, 12, 0, 6'h23), 32'h104, 0);
		add_row("and", enc_r(5, 6, 13, 0, 6'h24), 32'h108, 0);
		add_row("or", enc_r(5, 6, 14, 0, 6'h25), 32'h10c, 0);
		add_row("xor", enc_r(5, 6, 15, 0, 6'h26), 32'h110, 0);
		add_row("nor", enc_r(5, 6, 16, 0, 6'h27), 32'h114, 0);
		add_row("slt", enc_r(3, 2, 17, 0, 6'h2a), 32'h118, 0);
		add_row("sltu", enc_r(3, 2, 18, 0, 6'h2b), 32'h11c, 0);
		add_row("sll", enc_r(0, 6, 19, 7, 6'h00), 32'h120, 0);
		add_row("srl", enc_r(0, 4, 19, 31, 6'h02), 32'h124, 0);
		add_row("sra", enc_r(0, 4, 19, 4, 6'h03), 32'h128, 0);
		add_row("sllv", enc_r(2, 6, 23, 0, 6'h04), 32'h12c, 0);
		add_row("srlv", enc_r(5, 4, 23, 0, 6'h06), 32'h130, 0);
		add_row("srav", enc_r(5, 4, 23, 0, 6'h07), 32'h134, 0);
		// immediate forms
		add_row("addiu", enc_i(6'h09, 5, 24, 16'hfff0), 32'h138, 0);
		add_row("slti", enc_i(6'h0a, 3, 25, 16'h0001), 32'h13c, 0);
		add_row("sltiu", enc_i(6'h0b, 2, 25, 16'h8000), 32'h140, 0);
		add_row("andi", enc_i(6'h0c, 5, 26, 16'h8001), 32'h144, 0);
		add_row("ori", enc_i(6'h0d, 5, 26, 16'hf00f), 32'h148, 0);
		add_row("xori", enc_i(6'h0e, 3, 27, 16'h5a5a), 32'h14c, 0);
		add_row("aui", enc_i(6'h0f, 5, 28, 16'habcd), 32'h150, 0);
		// dependent chain, then same-cycle release
		add_row("dep_head", enc_r(5, 6, 20, 0, 6'h21), 32'h154, 0);
		add_row("dep_wait3", enc_i(6'h09, 20, 21, 16'h0005), 32'h158, 3);
		add_row("dep_same", enc_r(21, 9, 22, 0, 6'h21), 32'h15c, 1);
		// branches around zero and equality
		add_row("beq_t", enc_i(6'h04, 9, 10, 16'h0010), 32'h160, 0);
		add_row("beq_n", enc_i(6'h04, 9, 2, 16'h0010), 32'h164, 0);
		add_row("bne_n", enc_i(6'h05, 9, 10, 16'hfff8), 32'h168, 0);
		add_row("bne_t", enc_i(6'h05, 1, 2, 16'hfff8), 32'h16c, 0);
		add_row("blez_zero", enc_i(6'h06, 1, 0, 16'h0020), 32'h170, 0);
		add_row("blez_pos", enc_i(6'h06, 2, 0, 16'h0020), 32'h174, 0);
		add_row("blez_neg", enc_i(6'h06, 3, 0, 16'h8000), 32'h178, 0);
		add_row("bgtz_pos", enc_i(6'h07, 2, 0, 16'h0003), 32'h17c, 0);
		add_row("bgtz_zero", enc_i(6'h07, 1, 0, 16'h0003), 32'h180, 0);
		add_row("bltz_neg", enc_i(6'h01, 4, 0, 16'hffff), 32'h184, 0);
		add_row("bltz_zero", enc_i(6'h01, 1, 0, 16'hffff), 32'h188, 0);
		add_row("bgez_zero", enc_i(6'h01, 1, 1, 16'h0040), 32'h18c, 0);
		add_row("bgez_neg", enc_i(6'h01, 3, 1, 16'h0040), 32'h190, 0);
		// jumps
		add_row("j", {6'h02, 26'h0123456}, 32'hf000_0194, 0);
		add_row("jal", {6'h03, 26'h3ffffff}, 32'h1000_0198, 0);
		add_row("jr", enc_r(9, 0, 0, 0, 6'h08), 32'h19c, 0);
		add_row("jalr", enc_r(10, 0, 31, 0, 6'h09), 32'h1a0, 0);
		// unknown encodings
		add_row("bad_op", enc_i(6'h3f, 5, 6, 16'h1234), 32'h1a4, 0);
		add_row("bad_funct", enc_r(5, 6, 7, 0, 6'h3f), 32'h1a8, 0);

		max_delay = 1;
		foreach (row_delay[i]) begin
			if (row_delay[i] > max_delay) begin
				max_delay = row_delay[i];
			end
		end
		// preload, rows, a few extras
		cycle_limit = 60 + row_name.size() * (max_delay + 4) + 50;

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;
		@(negedge CLK);
		row_bad = 1'b0;
		compare_stall("reset", stall, 1'b0);
		compare_stall("reset_issue", issue.valid, 1'b0);
		compare_stall("reset_redirect", redirect.valid, 1'b0);
		finish_row("reset");

		// random contents, then fixed values for branch checks
		for (int r = 1; r < 32; r++) begin
			rand_word(v);
			write_reg(r, v);
		end
		write_reg(1, 32'h0);
		write_reg(2, 32'h1);
		write_reg(3, 32'hffff_ffff);
		write_reg(4, 32'h8000_0000);
		write_reg(9, 32'h0000_1234);
		write_reg(10, 32'h0000_1234);

		for (int i = 0; i < row_name.size(); i++) begin
			apply_row(i);
		end
		back_to_back();

		$display("passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/decode_pkg.sv
rtl/insn_classifier.sv
rtl/reg_scoreboard.sv
rtl/issue_stage.sv
rtl/decode_top.sv
dv/decode_properties.sv
dv/tb_decode.sv

// File: Makefile
LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_decode | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_decode -o Vtb_decode

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module tb_decode

clean:
	rm -rf obj_dir $(LOG)
